// ==== pack_pkg.sv ====
// packing subsystem definitions
`default_nettype none

package pack_pkg;

    // stream geometry
    localparam int WORD_W = 24;
    localparam int BEAT_W = 64;
    localparam int LANES  = 2;
    localparam int LANE_W = $clog2(LANES);

    // packer accumulator holds one partial beat plus one incoming word
    localparam int ACC_W  = BEAT_W + WORD_W;
    localparam int FILL_W = $clog2(ACC_W);

    // lane buffer, also the upstream credit budget
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // beats the downstream receiver can absorb
    localparam int OUT_CREDITS = 4;

    localparam int CUT_W = 16;

    localparam int CREDIT_MAX = (FIFO_DEPTH > OUT_CREDITS) ? FIFO_DEPTH : OUT_CREDITS;
    localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

    typedef logic [CREDIT_W-1:0] credit_cnt_t;
    typedef logic [FILL_W-1:0]   fill_t;

    // fill steps in accumulator width
    localparam fill_t WORD_STEP = fill_t'(WORD_W);
    localparam fill_t BEAT_STEP = fill_t'(BEAT_W);

    localparam credit_cnt_t OUT_CREDIT_INIT = credit_cnt_t'(OUT_CREDITS);

    // one narrow input word
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              last;
    } lane_word_t;

    // one wide packed beat
    typedef struct packed {
        logic [BEAT_W-1:0] data;
        logic              last;
    } lane_beat_t;

    // merged output beat tagged with its lane
    typedef struct packed {
        lane_beat_t        beat;
        logic [LANE_W-1:0] lane;
    } out_beat_t;

endpackage

`default_nettype wire

// ==== lane_fifo.sv ====
// lane input buffer
`timescale 1ns/100ps
`default_nettype none

module lane_fifo (
    input  logic                clock,
    input  logic                rst_n,
    input  pack_pkg::lane_word_t in_word,
    input  logic                in_valid,
    output logic                in_credit,
    output pack_pkg::lane_word_t out_word,
    output logic                out_valid,
    input  logic                out_ready
);

    pack_pkg::lane_word_t mem [pack_pkg::FIFO_DEPTH];

    logic [pack_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [pack_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [pack_pkg::FIFO_CNT_W-1:0] count;
    logic                            push;
    logic                            pop;

    // sender only writes while holding a credit, so no full check
    assign push = in_valid;
    assign pop  = out_valid && out_ready;

    assign out_valid = (count != '0);
    assign out_word  = mem[rd_ptr];

    // every word released frees one slot upstream
    assign in_credit = pop;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // pointers wrap naturally at the buffer depth
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== word_packer.sv ====
// narrow word to wide beat packer
`timescale 1ns/100ps
`default_nettype none

module word_packer (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic [pack_pkg::CUT_W-1:0] cut_len,
    input  pack_pkg::lane_word_t       in_word,
    input  logic                       in_valid,
    output logic                       in_ready,
    output pack_pkg::lane_beat_t       beat,
    output logic                       beat_valid,
    input  logic                       beat_ready
);

    // assembly state, bits held left-aligned
    logic [pack_pkg::ACC_W-1:0]  acc_q;
    logic [pack_pkg::ACC_W-1:0]  acc_d;
    pack_pkg::fill_t             fill_q;
    pack_pkg::fill_t             fill_d;

    // per-frame word position and mode
    logic [pack_pkg::CUT_W-1:0]  word_cnt_q;
    logic [pack_pkg::CUT_W-1:0]  word_cnt_d;
    logic                        drop_q;
    logic                        drop_d;
    logic                        flush_q;
    logic                        flush_d;

    // output holding slot
    pack_pkg::lane_beat_t        beat_q;
    pack_pkg::lane_beat_t        beat_d;
    logic                        beat_valid_q;
    logic                        beat_valid_d;

    logic                        out_free;
    logic                        xfer;
    logic                        keep;
    logic                        closing;
    logic [pack_pkg::ACC_W-1:0]  merged;
    logic [pack_pkg::ACC_W-1:0]  carry;
    pack_pkg::fill_t             sum_fill;

    assign out_free = !beat_valid_q || beat_ready;

    // dropped words never need the output slot
    assign in_ready = in_valid && (drop_q || (!flush_q && out_free));
    assign xfer     = in_valid && in_ready;
    assign keep     = xfer && !drop_q;

    // frame closes on last flag or on the cut-length word
    assign closing  = in_word.last || (word_cnt_q == cut_len - 1'b1);

    // new word lands right below the bits already held
    assign merged   = acc_q | ({in_word.data, {pack_pkg::BEAT_W{1'b0}}} >> fill_q);
    assign carry    = merged << pack_pkg::BEAT_W;
    assign sum_fill = fill_q + pack_pkg::WORD_STEP;

    always_comb begin
        acc_d        = acc_q;
        fill_d       = fill_q;
        word_cnt_d   = word_cnt_q;
        drop_d       = drop_q;
        flush_d      = flush_q;
        beat_d       = beat_q;
        beat_valid_d = beat_valid_q && !beat_ready;

        // leftover bits of a closed frame, zero-filled below
        if (flush_q && out_free) begin
            beat_d.data  = acc_q[pack_pkg::ACC_W-1 -: pack_pkg::BEAT_W];
            beat_d.last  = 1'b1;
            beat_valid_d = 1'b1;
            acc_d        = '0;
            fill_d       = '0;
            flush_d      = 1'b0;
        end

        // discard tail words up to the last flag
        if (xfer && drop_q && in_word.last) begin
            drop_d = 1'b0;
        end

        if (keep) begin
            if (closing) begin
                word_cnt_d = '0;
                drop_d     = !in_word.last;
            end else begin
                word_cnt_d = word_cnt_q + 1'b1;
            end

            if (sum_fill >= pack_pkg::BEAT_STEP) begin
                // full beat out, remainder carries over
                beat_d.data  = merged[pack_pkg::ACC_W-1 -: pack_pkg::BEAT_W];
                beat_d.last  = closing && (sum_fill == pack_pkg::BEAT_STEP);
                beat_valid_d = 1'b1;
                acc_d        = carry;
                fill_d       = sum_fill - pack_pkg::BEAT_STEP;
                flush_d      = closing && (sum_fill != pack_pkg::BEAT_STEP);
            end else if (closing) begin
                // short final beat
                beat_d.data  = merged[pack_pkg::ACC_W-1 -: pack_pkg::BEAT_W];
                beat_d.last  = 1'b1;
                beat_valid_d = 1'b1;
                acc_d        = '0;
                fill_d       = '0;
            end else begin
                acc_d  = merged;
                fill_d = sum_fill;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            acc_q        <= '0;
            fill_q       <= '0;
            word_cnt_q   <= '0;
            drop_q       <= 1'b0;
            flush_q      <= 1'b0;
            beat_valid_q <= 1'b0;
        end else begin
            acc_q        <= acc_d;
            fill_q       <= fill_d;
            word_cnt_q   <= word_cnt_d;
            drop_q       <= drop_d;
            flush_q      <= flush_d;
            beat_valid_q <= beat_valid_d;
        end
    end

    always_ff @(posedge clock) begin
        beat_q <= beat_d;
    end

    assign beat       = beat_q;
    assign beat_valid = beat_valid_q;

endmodule

`default_nettype wire

// ==== beat_merger.sv ====
// two-lane frame merger
`timescale 1ns/100ps
`default_nettype none

module beat_merger (
    input  logic                          clock,
    input  logic                          rst_n,
    input  pack_pkg::lane_beat_t          lane_beat [pack_pkg::LANES],
    input  logic [pack_pkg::LANES-1:0]    lane_valid,
    output logic [pack_pkg::LANES-1:0]    lane_ready,
    output pack_pkg::out_beat_t           out_beat,
    output logic                          out_valid,
    input  logic                          out_credit
);

    pack_pkg::credit_cnt_t        credit_q;
    logic                         locked_q;
    logic [pack_pkg::LANE_W-1:0]  owner_q;
    logic [pack_pkg::LANE_W-1:0]  prio_q;

    logic [pack_pkg::LANE_W-1:0]  other;
    logic [pack_pkg::LANE_W-1:0]  pick;
    logic [pack_pkg::LANE_W-1:0]  sel;
    logic                         can_send;
    logic                         accept;

    pack_pkg::out_beat_t          out_beat_q;
    logic                         out_valid_q;

    assign can_send = (credit_q != '0);

    // favoured lane first, else the other one
    assign other = prio_q + 1'b1;
    assign pick  = lane_valid[prio_q] ? prio_q : other;

    // stay on the owning lane until its frame ends
    assign sel = locked_q ? owner_q : pick;

    always_comb begin
        lane_ready      = '0;
        lane_ready[sel] = can_send && lane_valid[sel];
    end

    assign accept = lane_ready[sel];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            locked_q <= 1'b0;
            owner_q  <= '0;
            prio_q   <= '0;
        end else if (accept) begin
            if (lane_beat[sel].last) begin
                locked_q <= 1'b0;
                prio_q   <= sel + 1'b1;
            end else begin
                locked_q <= 1'b1;
                owner_q  <= sel;
            end
        end
    end

    // one credit spent per beat, one back per return pulse
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= pack_pkg::OUT_CREDIT_INIT;
        end else begin
            case ({accept, out_credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_beat_q.beat <= lane_beat[sel];
            out_beat_q.lane <= sel;
        end
    end

    assign out_beat  = out_beat_q;
    assign out_valid = out_valid_q;

endmodule

`default_nettype wire

// ==== pack_top.sv ====
// two-lane packing subsystem
`timescale 1ns/100ps
`default_nettype none

module pack_top (
    input  logic                       clock,
    input  logic                       rst_n,
    input  pack_pkg::lane_word_t       in_word [pack_pkg::LANES],
    input  logic [pack_pkg::LANES-1:0] in_valid,
    output logic [pack_pkg::LANES-1:0] in_credit,
    input  logic [pack_pkg::CUT_W-1:0] cut_len [pack_pkg::LANES],
    output pack_pkg::out_beat_t        out_beat,
    output logic                       out_valid,
    input  logic                       out_credit
);

    // fifo to packer
    pack_pkg::lane_word_t       fifo_word [pack_pkg::LANES];
    logic [pack_pkg::LANES-1:0] fifo_valid;
    logic [pack_pkg::LANES-1:0] fifo_ready;

    // packer to merger
    pack_pkg::lane_beat_t       lane_beat [pack_pkg::LANES];
    logic [pack_pkg::LANES-1:0] lane_valid;
    logic [pack_pkg::LANES-1:0] lane_ready;

    for (genvar g = 0; g < pack_pkg::LANES; g++) begin : g_lane
        lane_fifo u_fifo (
            .clock     (clock),
            .rst_n     (rst_n),
            .in_word   (in_word[g]),
            .in_valid  (in_valid[g]),
            .in_credit (in_credit[g]),
            .out_word  (fifo_word[g]),
            .out_valid (fifo_valid[g]),
            .out_ready (fifo_ready[g])
        );

        word_packer u_packer (
            .clock      (clock),
            .rst_n      (rst_n),
            .cut_len    (cut_len[g]),
            .in_word    (fifo_word[g]),
            .in_valid   (fifo_valid[g]),
            .in_ready   (fifo_ready[g]),
            .beat       (lane_beat[g]),
            .beat_valid (lane_valid[g]),
            .beat_ready (lane_ready[g])
        );
    end

    beat_merger u_merger (
        .clock      (clock),
        .rst_n      (rst_n),
        .lane_beat  (lane_beat),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

endmodule

`default_nettype wire

// ==== tb_pack_top.sv ====
// packing subsystem testbench
`timescale 1ns/100ps
`default_nettype none

module tb_pack_top;

    localparam int TIMEOUT = 4000;

    logic                       clock;
    logic                       rst_n;
    pack_pkg::lane_word_t       in_word [pack_pkg::LANES];
    logic [pack_pkg::LANES-1:0] in_valid;
    logic [pack_pkg::LANES-1:0] in_credit;
    logic [pack_pkg::CUT_W-1:0] cut_len [pack_pkg::LANES];
    pack_pkg::out_beat_t        out_beat;
    logic                       out_valid;
    logic                       out_credit;

    // record layout: lane, cut, count, words
    logic [23:0]         stim [0:127];
    pack_pkg::out_beat_t exp0 [$];
    pack_pkg::out_beat_t exp1 [$];
    int                  sent [2];
    int                  returned [2];
    int                  started [2];
    int                  done_frames [2];
    int                  beats_seen;
    int                  ret_cnt;
    int                  ret_lag;
    int                  given;
    int                  tests;
    int                  errors;
    bit                  finished;
    bit                  in_frame;
    logic                owner;

    pack_top DUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_word    (in_word),
        .in_valid   (in_valid),
        .in_credit  (in_credit),
        .cut_len    (cut_len),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

    always #10 clock = ~clock;

    task automatic check_beat(input pack_pkg::out_beat_t got, input pack_pkg::out_beat_t exp);
        tests++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: out_beat expected %h got %h", $time, exp, got);
        end else begin
            $display("beat %0d lane %0d last %0b ok", tests, got.lane, got.beat.last);
        end
    endtask

    task automatic check_credits(input string name, input pack_pkg::credit_cnt_t got,
                                 input pack_pkg::credit_cnt_t exp);
        tests++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
        end else begin
            $display("%s ok at %0d", name, got);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    function automatic int sender_credit(input int lane);
        return pack_pkg::FIFO_DEPTH - sent[lane] + returned[lane];
    endfunction

    // expected beats straight from the bit order, msb first
    task automatic build_expected(input int base, input int lane, input int cut, input int cnt);
        int                  kept;
        int                  nbits;
        int                  nbeats;
        int                  i;
        int                  src;
        int                  pos;
        pack_pkg::out_beat_t b;
        kept   = (cnt < cut) ? cnt : cut;
        nbits  = kept * pack_pkg::WORD_W;
        nbeats = (nbits + pack_pkg::BEAT_W - 1) / pack_pkg::BEAT_W;
        for (int n = 0; n < nbeats; n++) begin
            b = '0;
            b.lane = lane[0];
            b.beat.last = (n == nbeats - 1);
            for (int k = 0; k < pack_pkg::BEAT_W; k++) begin
                i = n * pack_pkg::BEAT_W + k;
                if (i < nbits) begin
                    src = base + i / pack_pkg::WORD_W;
                    pos = pack_pkg::WORD_W - 1 - i % pack_pkg::WORD_W;
                    b.beat.data[pack_pkg::BEAT_W-1-k] = stim[src][pos];
                end
            end
            if (lane == 0) exp0.push_back(b);
            else exp1.push_back(b);
        end
    endtask

    task automatic drive_lane(input int lane);
        int ptr;
        int cut;
        int cnt;
        int idx;
        int waited;
        ptr = 1;
        for (int f = 0; f < stim[0]; f++) begin
            cut = stim[ptr+1];
            cnt = stim[ptr+2];
            if (stim[ptr] == lane) begin
                // cut length may only change once the lane is idle
                waited = 0;
                while (done_frames[lane] != started[lane]) begin
                    @(posedge clock);
                    waited++;
                    if (waited > TIMEOUT) abort_on_timeout("previous frame to close");
                end
                @(posedge clock);
                cut_len[lane] <= cut[pack_pkg::CUT_W-1:0];
                started[lane]++;
                idx = 0;
                waited = 0;
                while (idx < cnt) begin
                    @(posedge clock);
                    if (sender_credit(lane) > 0) begin
                        in_word[lane]  <= '{data: stim[ptr+3+idx], last: (idx == cnt - 1)};
                        in_valid[lane] <= 1'b1;
                        sent[lane]++;
                        idx++;
                        waited = 0;
                    end else begin
                        in_valid[lane] <= 1'b0;
                        waited++;
                        if (waited > TIMEOUT) abort_on_timeout("an upstream credit");
                    end
                end
                @(posedge clock);
                in_valid[lane] <= 1'b0;
            end
            ptr = ptr + 3 + cnt;
        end
    endtask

    // beat checker, merge integrity and downstream credit model
    always @(posedge clock) begin
        pack_pkg::out_beat_t exp;
        for (int l = 0; l < 2; l++) begin
            if (in_credit[l]) returned[l]++;
        end
        if (out_valid) begin
            if (pack_pkg::OUT_CREDITS - beats_seen + ret_lag <= 0) begin
                errors++;
                $display("out_valid rose at %0t with no downstream credit left", $time);
            end
            beats_seen++;
            if (in_frame && out_beat.lane != owner) begin
                errors++;
                $display("lane %0d beat cut into an open frame of the other lane at %0t",
                         out_beat.lane, $time);
            end
            in_frame = !out_beat.beat.last;
            owner    = out_beat.lane;
            if ((out_beat.lane == 0 ? exp0.size() : exp1.size()) == 0) begin
                errors++;
                $display("unexpected extra beat on lane %0d at %0t", out_beat.lane, $time);
            end else begin
                exp = (out_beat.lane == 0) ? exp0.pop_front() : exp1.pop_front();
                check_beat(out_beat, exp);
            end
            if (out_beat.beat.last) done_frames[out_beat.lane]++;
        end
        ret_lag = ret_cnt;
        if (out_credit) ret_cnt++;
    end

    // downstream receiver returns credits after a random delay
    initial begin
        int delay;
        void'($urandom(32'h26b));
        while (!finished) begin
            @(posedge clock);
            out_credit <= 1'b0;
            if (given < beats_seen) begin
                delay = $urandom % 7;
                repeat (delay) @(posedge clock);
                out_credit <= 1'b1;
                given++;
            end
        end
    end

    initial begin
        int ptr;
        int waited;
        clock      = 1'b0;
        rst_n      = 1'b0;
        in_valid   = '0;
        out_credit = 1'b0;
        for (int l = 0; l < 2; l++) begin
            in_word[l] = '0;
            cut_len[l] = '1;
        end
        $readmemh("tb_pack_input.txt", stim);
        ptr = 1;
        for (int f = 0; f < stim[0]; f++) begin
            build_expected(ptr + 3, stim[ptr], stim[ptr+1], stim[ptr+2]);
            ptr = ptr + 3 + stim[ptr+2];
        end
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        fork
            drive_lane(0);
            drive_lane(1);
        join
        waited = 0;
        while (exp0.size() != 0 || exp1.size() != 0 || ret_cnt != beats_seen) begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT) abort_on_timeout("all beats and credits to drain");
        end
        repeat (2) @(posedge clock);
        finished = 1'b1;
        check_credits("lane 0 sender credit", pack_pkg::credit_cnt_t'(sender_credit(0)),
                      pack_pkg::credit_cnt_t'(pack_pkg::FIFO_DEPTH));
        check_credits("lane 1 sender credit", pack_pkg::credit_cnt_t'(sender_credit(1)),
                      pack_pkg::credit_cnt_t'(pack_pkg::FIFO_DEPTH));
        $display("%0d checks, %0d errors, %0d beats", tests, errors, beats_seen);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_pack_input.txt ====
// first value is the frame count
// then per frame: lane, cut length, word count, words (hex)
7
// lane 0 uncut, 120 bits, zero-filled final beat
0 ff 5
a1b2c3 d4e5f6 102030 405060 708090
// lane 1 uncut, ends exactly on a beat boundary
1 ff 8
111111 222222 333333 444444
555555 666666 777777 888888
// lane 0 cut to 3 of 7 words
0 3 7
abcdef 123456 fedcba 0f0f0f f0f0f0 deadbe efcafe
// lane 1 cut to 2 of 4 words
1 2 4
c0ffee 00beef 55aa55 aa55aa
// lane 0 uncut, boundary again
0 ff 8
010203 040506 070809 0a0b0c
0d0e0f 101112 131415 161718
// lane 1 single word
1 ff 1
ffffff
// lane 0 cut at a beat boundary, two words dropped
0 8 a
800001 400002 200004 100008
080010 040020 020040 010080
ababab cdcdcd

// ==== project.f ====
pack_pkg.sv
lane_fifo.sv
word_packer.sv
beat_merger.sv
pack_top.sv
tb_pack_top.sv

// ==== Bender.yml ====
package:
  name: pack_top

sources:
  - pack_pkg.sv
  - lane_fifo.sv
  - word_packer.sv
  - beat_merger.sv
  - pack_top.sv
  - target: simulation
    files:
      - tb_pack_top.sv
